/* verilog/cart_pkg.sv */
/*
 * Cartridge loader shared definitions
 * Host load bus, header layout, quirk and cheat-code formats, console regions
 */
package cart_pkg;

	localparam int LOAD_ADDR_W = 25;
	localparam int LOAD_DATA_W = 16;
	localparam int ROM_ADDR_W  = LOAD_ADDR_W - 1;

	typedef logic [LOAD_ADDR_W-1:0] load_addr_t;
	typedef logic [LOAD_DATA_W-1:0] load_data_t;
	typedef logic [ROM_ADDR_W-1:0]  rom_addr_t;
	typedef logic [7:0]             load_index_t;
	// Eight ASCII characters, first character in the top byte
	typedef logic [63:0]            product_id_t;

	// One host write, as seen on the download port
	typedef struct packed {
		logic        download;
		logic        wr;
		load_addr_t  addr;
		load_data_t  data;
		load_index_t index;
	} load_bus_t;

	typedef enum logic [1:0] {
		REGION_JP = 2'd0,
		REGION_US = 2'd1,
		REGION_EU = 2'd2
	} region_t;

	typedef struct packed {
		logic hdr_j;
		logic hdr_u;
		logic hdr_e;
	} region_flags_t;

	typedef struct packed {
		logic sram;
		logic eeprom;
		logic noram;
		logic fifo;
		logic pier;
		logic svp;
		logic fmbusy;
	} cart_quirks_t;

	// Fields are big endian 32-bit values as delivered by the code file
	typedef struct packed {
		logic [31:0] flags;
		logic [31:0] address;
		logic [31:0] compare;
		logic [31:0] replace;
	} cheat_code_t;

	//////////////////////////////////////////////////
	// Header byte addresses

	localparam load_addr_t HDR_ID_FIRST = 25'h182;
	localparam load_addr_t HDR_ID_LAST  = 25'h18A;
	localparam load_addr_t HDR_ID_DONE  = 25'h18C;
	localparam load_addr_t HDR_REGION_0 = 25'h1F0;
	localparam load_addr_t HDR_REGION_1 = 25'h1F2;
	localparam load_addr_t HDR_END      = 25'h200;

	// Download index reserved for cheat codes
	localparam load_index_t CODE_INDEX = 8'hFF;

	// Host words arrive little endian, cartridge data is big endian
	function automatic load_data_t swap_bytes(input load_data_t w);
		return {w[7:0], w[15:8]};
	endfunction

endpackage

/* verilog/rom_write_port.sv */
/*
 * ROM write port
 * Byte-swapped word writes to storage with toggle handshake and host wait
 */
`timescale 1ns/1ps

module rom_write_port import cart_pkg::*; (
	input  logic       clk_sys,
	input  logic       RESET,
	input  load_bus_t  load,
	input  logic       cart_download,
	output logic       ioctl_wait,
	output logic       rom_req,
	output rom_addr_t  rom_addr,
	output load_data_t rom_data,
	input  logic       rom_ack,
	output load_addr_t rom_size
);

	logic       old_download;
	logic       rom_wr;
	load_addr_t last_addr;

	assign rom_wr = load.wr & cart_download;

	// Address and data stay put until the next cartridge write
	always_ff @(posedge clk_sys) begin
		if (rom_wr) begin
			rom_addr  <= load.addr[LOAD_ADDR_W-1:1];
			rom_data  <= swap_bytes(load.data);
			last_addr <= load.addr;
		end
	end

	//////////////////////////////////////////////////
	// Handshake and size capture

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			old_download <= 1'b0;
			ioctl_wait   <= 1'b0;
			rom_req      <= 1'b0;
			rom_size     <= '0;
		end else begin
			old_download <= cart_download;

			if (old_download && !cart_download)
				rom_size <= last_addr;

			if (rom_wr) begin
				ioctl_wait <= 1'b1;
				rom_req    <= ~rom_req;
			end else if (ioctl_wait && (rom_ack == rom_req)) begin
				// Storage has caught up with the last toggle
				ioctl_wait <= 1'b0;
			end
		end
	end

endmodule

/* verilog/cart_header_parser.sv */
/*
 * Cartridge header parser
 * Picks region letters and product ID out of the download, looks up quirks
 */
`timescale 1ns/1ps

module cart_header_parser import cart_pkg::*; (
	input  logic          clk_sys,
	input  logic          RESET,
	input  load_bus_t     load,
	input  logic          cart_download,
	output region_flags_t flags,
	output cart_quirks_t  quirks,
	output logic          hdr_ready
);

	logic        old_download;
	logic        hdr_wr;
	product_id_t cart_id;

	assign hdr_wr = load.wr & cart_download;

	// One region character, first matching rule wins
	function automatic region_flags_t classify_letter(input logic [7:0] c);
		region_flags_t f;
		f = '0;
		if (c == "J")
			f.hdr_j = 1'b1;
		else if (c == "U")
			f.hdr_u = 1'b1;
		else if (c >= "0" && c <= "Z")
			f.hdr_e = 1'b1;
		return f;
	endfunction

	// Known titles that need special handling
	function automatic cart_quirks_t lookup_quirks(input product_id_t id);
		cart_quirks_t q;
		q = '0;
		case (id)
			"T-081276", "T-81406 ":             q.sram   = 1'b1;
			"MK-1215 ", "G-4060  ", "T-12046 ": q.eeprom = 1'b1;
			"T-113016":                         q.noram  = 1'b1;
			"T-89016 ":                         q.fifo   = 1'b1;
			"T-574023", "T-574013":             q.pier   = 1'b1;
			"MK-1229 ", "G-7001  ":             q.svp    = 1'b1;
			"T-35036 ":                         q.fmbusy = 1'b1;
			default:                            q        = '0;
		endcase
		return q;
	endfunction

	//////////////////////////////////////////////////
	// Header capture

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			old_download <= 1'b0;
			flags        <= '0;
			quirks       <= '0;
			hdr_ready    <= 1'b0;
		end else begin
			old_download <= cart_download;

			// New image, forget the previous header
			if (!old_download && cart_download) begin
				flags  <= '0;
				quirks <= '0;
			end
			if (old_download && !cart_download)
				hdr_ready <= 1'b0;

			if (hdr_wr) begin
				case (load.addr)
					// ID starts on the odd byte of the first word
					HDR_ID_FIRST:     cart_id[63:56] <= load.data[15:8];
					HDR_ID_FIRST + 2: cart_id[55:40] <= swap_bytes(load.data);
					HDR_ID_FIRST + 4: cart_id[39:24] <= swap_bytes(load.data);
					HDR_ID_FIRST + 6: cart_id[23:8]  <= swap_bytes(load.data);
					HDR_ID_LAST:      cart_id[7:0]   <= load.data[7:0];
					HDR_ID_DONE:      quirks <= lookup_quirks(cart_id);
					HDR_REGION_0: begin
						flags <= flags | classify_letter(load.data[7:0])
							| classify_letter(load.data[15:8]);
					end
					HDR_REGION_1:     flags <= flags | classify_letter(load.data[7:0]);
					HDR_END:          hdr_ready <= 1'b1;
					default: ;
				endcase
			end
		end
	end

endmodule

/* verilog/region_select.sv */
/*
 * Console region selection
 * Uses header letters in priority order, or the file index, when the header is in
 */
`timescale 1ns/1ps

module region_select import cart_pkg::*; (
	input  logic          clk_sys,
	input  logic          RESET,
	input  region_flags_t flags,
	input  logic          hdr_ready,
	input  logic          region_auto,
	input  logic          region_from_header,
	input  logic [1:0]    region_priority,
	input  load_index_t   file_index,
	output region_t       region_req,
	output logic          region_set
);

	logic old_ready;

	// First present letter in the chosen order, else the head of that order
	function automatic region_t pick_region(input region_flags_t f, input logic [1:0] prio);
		region_t r;
		case (prio)
			2'd0: r = f.hdr_u ? REGION_US : f.hdr_e ? REGION_EU : f.hdr_j ? REGION_JP : REGION_US;
			2'd1: r = f.hdr_e ? REGION_EU : f.hdr_u ? REGION_US : f.hdr_j ? REGION_JP : REGION_EU;
			2'd2: r = f.hdr_u ? REGION_US : f.hdr_j ? REGION_JP : f.hdr_e ? REGION_EU : REGION_US;
			default: r = f.hdr_j ? REGION_JP : f.hdr_u ? REGION_US : f.hdr_e ? REGION_EU : REGION_JP;
		endcase
		return r;
	endfunction

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			old_ready  <= 1'b0;
			region_set <= 1'b0;
			region_req <= REGION_JP;
		end else begin
			old_ready <= hdr_ready;

			if (region_auto && !old_ready && hdr_ready) begin
				if (region_from_header) begin
					region_set <= 1'b1;
					region_req <= pick_region(flags, region_priority);
				end else begin
					// Index encodes the region in its top bits, zero means no choice
					region_set <= |file_index;
					region_req <= region_t'(file_index[7:6]);
				end
			end

			if (old_ready && !hdr_ready)
				region_set <= 1'b0;
		end
	end

endmodule

/* verilog/cheat_code_loader.sv */
/*
 * Cheat code loader
 * Builds 128-bit codes from code-download words, strobes each finished code
 */
`timescale 1ns/1ps

module cheat_code_loader import cart_pkg::*; #(
	parameter int CHEAT_WORDS = 8
) (
	input  logic        clk_sys,
	input  logic        RESET,
	input  load_bus_t   load,
	input  logic        code_download,
	output cheat_code_t cheat_code,
	output logic        cheat_valid,
	output logic        cheat_reset
);

	localparam logic [3:0] LAST_OFFSET = 4'((CHEAT_WORDS - 1) * 2);

	logic [3:0] offset;
	logic [6:0] slot_lsb;
	logic       code_wr;

	assign offset  = load.addr[3:0];
	assign code_wr = load.wr & code_download;

	// Field 3 - offset/4, low half first; 3 - x on two bits is ~x
	assign slot_lsb = {~offset[3:2], offset[1], 4'b0000};

	always_ff @(posedge clk_sys) begin
		if (code_wr)
			cheat_code[slot_lsb +: 16] <= load.data;
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			cheat_valid <= 1'b0;
			cheat_reset <= 1'b0;
		end else begin
			cheat_valid <= code_wr && (offset == LAST_OFFSET);
			// Start of a code file drops all codes loaded before
			cheat_reset <= code_wr && (load.addr == '0);
		end
	end

endmodule

/* verilog/cart_loader_top.sv */
/*
 * Cartridge load controller top level
 * Splits host downloads into cartridge and cheat-code streams
 */
`timescale 1ns/1ps

module cart_loader_top import cart_pkg::*; #(
	parameter int CHEAT_WORDS = 8
) (
	input  logic         clk_sys,
	input  logic         RESET,
	input  load_bus_t    load,
	input  logic         region_auto,
	input  logic         region_from_header,
	input  logic [1:0]   region_priority,
	output logic         ioctl_wait,
	output logic         rom_req,
	output rom_addr_t    rom_addr,
	output load_data_t   rom_data,
	input  logic         rom_ack,
	output load_addr_t   rom_size,
	output region_t      region_req,
	output logic         region_set,
	output cart_quirks_t quirks,
	output cheat_code_t  cheat_code,
	output logic         cheat_valid,
	output logic         cheat_reset
);

	logic          code_index;
	logic          cart_download;
	logic          code_download;
	region_flags_t flags;
	logic          hdr_ready;

	// All-ones index selects the cheat-code file
	assign code_index    = (load.index == CODE_INDEX);
	assign cart_download = load.download & ~code_index;
	assign code_download = load.download & code_index;

	cart_header_parser u_parser (
		.clk_sys       (clk_sys),
		.RESET         (RESET),
		.load          (load),
		.cart_download (cart_download),
		.flags         (flags),
		.quirks        (quirks),
		.hdr_ready     (hdr_ready)
	);

	region_select u_region (
		.clk_sys            (clk_sys),
		.RESET              (RESET),
		.flags              (flags),
		.hdr_ready          (hdr_ready),
		.region_auto        (region_auto),
		.region_from_header (region_from_header),
		.region_priority    (region_priority),
		.file_index         (load.index),
		.region_req         (region_req),
		.region_set         (region_set)
	);

	cheat_code_loader #(.CHEAT_WORDS(CHEAT_WORDS)) u_cheat (
		.clk_sys       (clk_sys),
		.RESET         (RESET),
		.load          (load),
		.code_download (code_download),
		.cheat_code    (cheat_code),
		.cheat_valid   (cheat_valid),
		.cheat_reset   (cheat_reset)
	);

	rom_write_port u_rom (
		.clk_sys       (clk_sys),
		.RESET         (RESET),
		.load          (load),
		.cart_download (cart_download),
		.ioctl_wait    (ioctl_wait),
		.rom_req       (rom_req),
		.rom_addr      (rom_addr),
		.rom_data      (rom_data),
		.rom_ack       (rom_ack),
		.rom_size      (rom_size)
	);

endmodule

/* tb/cart_loader_sva.sv */
/*
 * Handshake assertions for the cartridge load controller
 */
`timescale 1ns/1ps

module cart_loader_sva import cart_pkg::*; (
	input logic       clk_sys,
	input logic       RESET,
	input load_bus_t  load,
	input logic       ioctl_wait,
	input logic       rom_req,
	input logic       rom_ack,
	input rom_addr_t  rom_addr,
	input load_data_t rom_data,
	input logic       cheat_valid
);

	int fail_count = 0;

	// Each request toggle comes with the wait flag
	assert property (@(posedge clk_sys) disable iff (RESET) $changed(rom_req) |-> ioctl_wait)
		else begin
			$error("rom_req toggled without ioctl_wait");
			fail_count++;
		end

	assert property (@(posedge clk_sys) disable iff (RESET)
		$fell(ioctl_wait) |-> $past(rom_ack == rom_req))
		else begin
			$error("ioctl_wait fell before storage acknowledged");
			fail_count++;
		end

	// Host side must hold off while waiting
	assert property (@(posedge clk_sys) disable iff (RESET) load.wr |-> !ioctl_wait)
		else begin
			$error("host write while ioctl_wait was high");
			fail_count++;
		end

	assert property (@(posedge clk_sys) disable iff (RESET)
		ioctl_wait |=> $stable(rom_addr) && $stable(rom_data))
		else begin
			$error("storage address or data moved during a request");
			fail_count++;
		end

	assert property (@(posedge clk_sys) disable iff (RESET) cheat_valid |=> !cheat_valid)
		else begin
			$error("cheat_valid longer than one cycle");
			fail_count++;
		end

endmodule

/* tb/cart_loader_tb.sv */
/*
 * Testbench for the cartridge load controller
 * Downloads header images and cheat codes into a storage model and checks the results
 */
`timescale 1ns/1ps

module cart_loader_tb import cart_pkg::*; ();

	localparam int IMG_BYTES  = 'h202;
	localparam int WAIT_LIMIT = 20;
	localparam int N_ROWS     = 11;
	localparam int N_CODES    = 3;

	// One cartridge image and what the controller should make of it
	typedef struct packed {
		logic [31:0] region_chars;
		logic [63:0] id;
		logic        auto_on;
		logic        from_header;
		logic [1:0]  prio;
		logic [7:0]  index;
		logic [1:0]  exp_region;
		logic        exp_set;
		logic [6:0]  exp_quirks;
	} cart_row_t;

	logic         clk_sys = 1'b0;
	logic         RESET;
	load_bus_t    load;
	logic         region_auto;
	logic         region_from_header;
	logic [1:0]   region_priority;
	logic         rom_ack = 1'b0;
	logic         ioctl_wait;
	logic         rom_req;
	rom_addr_t    rom_addr;
	load_data_t   rom_data;
	load_addr_t   rom_size;
	region_t      region_req;
	logic         region_set;
	cart_quirks_t quirks;
	cheat_code_t  cheat_code;
	logic         cheat_valid;
	logic         cheat_reset;

	cart_row_t   cart_rows [N_ROWS];
	cheat_code_t cheat_rows [N_CODES];
	logic [7:0]  image [0:IMG_BYTES-1];
	load_data_t  storage [0:511];
	logic        ack_busy = 1'b0;
	int          ack_delay = 0;
	int          valid_count = 0;
	int          reset_count = 0;
	cheat_code_t captured_code;
	// Request level after one toggle per cartridge word
	logic        req_level = 1'b0;
	int          checks = 0;
	int          errors = 0;
	int          timeouts = 0;

	always #50 clk_sys = ~clk_sys;

	cart_loader_top #(.CHEAT_WORDS(8)) dut (.*);

	bind cart_loader_top cart_loader_sva u_sva (
		.clk_sys (clk_sys), .RESET (RESET), .load (load),
		.ioctl_wait (ioctl_wait), .rom_req (rom_req), .rom_ack (rom_ack),
		.rom_addr (rom_addr), .rom_data (rom_data), .cheat_valid (cheat_valid)
	);

	//////////////////////////////////////////////////
	// Storage model answering each toggle after a random delay

	always @(posedge clk_sys) begin
		if (ack_busy) begin
			if (ack_delay == 0) begin
				storage[rom_addr[8:0]] <= rom_data;
				rom_ack  <= rom_req;
				ack_busy <= 1'b0;
			end else begin
				ack_delay <= ack_delay - 1;
			end
		end else if (rom_req != rom_ack) begin
			ack_busy  <= 1'b1;
			ack_delay <= $urandom_range(3, 0);
		end
	end

	// Cheat strobes seen on the outputs
	always @(posedge clk_sys) begin
		if (cheat_valid) begin
			valid_count   <= valid_count + 1;
			captured_code <= cheat_code;
		end
		if (cheat_reset)
			reset_count <= reset_count + 1;
	end

	task automatic check_value(input string name, input logic [127:0] got,
		input logic [127:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Fail %s: got %h, expected %h", name, got, exp);
		end
	endtask

	// Quirk bits in order sram eeprom noram fifo pier svp fmbusy
	task automatic fill_tables();
		cart_rows[0]  = '{"U  J", "T-081276", 1'b1, 1'b1, 2'd3, 8'h00, REGION_US, 1'b1, 7'b1000000};
		cart_rows[1]  = '{"JE  ", "MK-1215 ", 1'b1, 1'b1, 2'd1, 8'h00, REGION_EU, 1'b1, 7'b0100000};
		cart_rows[2]  = '{"J   ", "T-113016", 1'b1, 1'b1, 2'd2, 8'h00, REGION_JP, 1'b1, 7'b0010000};
		cart_rows[3]  = '{"E4  ", "T-89016 ", 1'b1, 1'b1, 2'd3, 8'h00, REGION_EU, 1'b1, 7'b0001000};
		cart_rows[4]  = '{"ab  ", "T-574023", 1'b1, 1'b1, 2'd1, 8'h00, REGION_EU, 1'b1, 7'b0000100};
		cart_rows[5]  = '{"    ", "G-7001  ", 1'b1, 1'b1, 2'd3, 8'h00, REGION_JP, 1'b1, 7'b0000010};
		cart_rows[6]  = '{"JUE ", "T-35036 ", 1'b1, 1'b1, 2'd3, 8'h00, REGION_JP, 1'b1, 7'b0000001};
		cart_rows[7]  = '{"J   ", "T-12046 ", 1'b1, 1'b0, 2'd0, 8'h81, REGION_EU, 1'b1, 7'b0100000};
		cart_rows[8]  = '{"U   ", "T-99999 ", 1'b1, 1'b0, 2'd0, 8'h00, REGION_JP, 1'b0, 7'b0000000};
		cart_rows[9]  = '{"    ", "T-81406 ", 1'b0, 1'b1, 2'd0, 8'h40, REGION_JP, 1'b0, 7'b1000000};
		cart_rows[10] = '{"    ", "MK-1229 ", 1'b1, 1'b1, 2'd0, 8'h00, REGION_US, 1'b1, 7'b0000010};
		cheat_rows[0] = '{32'h0000_0001, 32'h00FF_0A24, 32'h0000_0000, 32'h0000_0063};
		cheat_rows[1] = '{32'h8000_0000, 32'h0001_2345, 32'h0000_4E75, 32'h0000_4E71};
		cheat_rows[2] = '{32'h0000_0002, 32'h00E0_F00C, 32'hDEAD_BEEF, 32'h1234_5678};
	endtask

	// Filler from the whole address and the row under the header fields
	task automatic build_image(input int r, input cart_row_t row);
		for (int a = 0; a < IMG_BYTES; a++)
			image[a] = 8'(a ^ ((a >> 8) * 29 + r * 37));
		for (int i = 0; i < 8; i++)
			image[HDR_ID_FIRST + 1 + i] = row.id[63 - 8 * i -: 8];
		for (int i = 0; i < 4; i++)
			image[HDR_REGION_0 + i] = row.region_chars[31 - 8 * i -: 8];
	endtask

	// One host write, then hold off while the controller waits on storage
	task automatic host_write(input load_addr_t addr, input load_data_t data, input logic to_rom);
		int cycles;
		load.wr   <= 1'b1;
		load.addr <= addr;
		load.data <= data;
		if (to_rom)
			req_level = ~req_level;
		@(posedge clk_sys);
		load.wr <= 1'b0;
		cycles = 0;
		@(posedge clk_sys);
		check_value("ioctl_wait", ioctl_wait, to_rom);
		while (ioctl_wait && cycles < WAIT_LIMIT) begin
			cycles++;
			@(posedge clk_sys);
		end
		if (ioctl_wait) begin
			timeouts++;
			$display("Timeout: ioctl_wait still high after the write to %h", addr);
		end else if (to_rom) begin
			check_value("rom_req", rom_req, req_level);
			check_value("rom_ack", rom_ack, req_level);
		end
	endtask

	task automatic run_cart_row(input int r);
		cart_row_t row;
		row = cart_rows[r];
		build_image(r, row);
		region_auto        <= row.auto_on;
		region_from_header <= row.from_header;
		region_priority    <= row.prio;
		load.index         <= row.index;
		load.download      <= 1'b1;
		@(posedge clk_sys);
		for (int w = 0; w < IMG_BYTES; w += 2)
			host_write(load_addr_t'(w), {image[w + 1], image[w]}, 1'b1);
		// Header results must be out before the download ends
		check_value("region_req", region_req, row.exp_region);
		check_value("region_set", region_set, row.exp_set);
		check_value("quirks", quirks, row.exp_quirks);
		load.download <= 1'b0;
		repeat (4) @(posedge clk_sys);
		check_value("rom_size", rom_size, IMG_BYTES - 2);
		check_value("region_set after download", region_set, 1'b0);
		for (int w = 0; w < IMG_BYTES / 2; w++)
			check_value($sformatf("storage[%h]", w), storage[w], {image[2 * w], image[2 * w + 1]});
	endtask

	// Offsets 0 and 2 carry the low and high half of flags and so on
	function automatic load_data_t code_word(input cheat_code_t code, input int k);
		logic [31:0] field;
		field = 32'(code >> (96 - 32 * (k / 2)));
		return (k % 2 == 1) ? field[31:16] : field[15:0];
	endfunction

	task automatic run_code_download();
		load.index    <= CODE_INDEX;
		load.download <= 1'b1;
		@(posedge clk_sys);
		for (int c = 0; c < N_CODES; c++) begin
			for (int k = 0; k < 8; k++)
				host_write(load_addr_t'(c * 16 + k * 2), code_word(cheat_rows[c], k), 1'b0);
			@(posedge clk_sys);
			check_value("cheat_code", captured_code, cheat_rows[c]);
			check_value("cheat_valid pulses", valid_count, c + 1);
		end
		load.download <= 1'b0;
		@(posedge clk_sys);
		check_value("cheat_reset pulses", reset_count, 1);
	endtask

	//////////////////////////////////////////////////
	// Main sequence

	initial begin
		void'($urandom(32'h120e3fee));
		RESET              <= 1'b1;
		load               <= '0;
		region_auto        <= 1'b0;
		region_from_header <= 1'b0;
		region_priority    <= 2'd0;
		fill_tables();
		repeat (5) @(posedge clk_sys);
		RESET <= 1'b0;
		@(posedge clk_sys);
		check_value("ioctl_wait", ioctl_wait, 1'b0);
		check_value("rom_req", rom_req, 1'b0);
		check_value("region_set", region_set, 1'b0);
		check_value("cheat_valid", cheat_valid, 1'b0);
		check_value("cheat_reset", cheat_reset, 1'b0);
		for (int r = 0; r < N_ROWS; r++)
			run_cart_row(r);
		run_code_download();
		$display("Checks %0d, mismatches %0d, timeouts %0d, assertion failures %0d",
			checks, errors, timeouts, dut.u_sva.fail_count);
		if (errors == 0 && timeouts == 0 && dut.u_sva.fail_count == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

/* filelist.f */
verilog/cart_pkg.sv
verilog/rom_write_port.sv
verilog/cart_header_parser.sv
verilog/region_select.sv
verilog/cheat_code_loader.sv
verilog/cart_loader_top.sv
tb/cart_loader_sva.sv
tb/cart_loader_tb.sv

/* run.sh */
#!/bin/sh
# Build the testbench with Verilator, run it, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module cart_loader_tb -f filelist.f &&
	./obj_dir/Vcart_loader_tb 2>&1 | tee sim.log
grep -qx "Testbench passed" sim.log 2>/dev/null && echo "run.sh: PASS" ||
	{ echo "run.sh: FAIL"; exit 1; }
